// File: hdmi_frame.f
+incdir+logic
+incdir+tests
logic/hdmi_pkg.sv
logic/byte_packer.sv
logic/vram_plane.sv
logic/scan_reader.sv
logic/hdmi_frame_top.sv
tests/hdmi_frame_tb.sv

// File: Bender.yml
package:
  name: hdmi_frame

sources:
  # synthesizable design
  - include_dirs:
      - logic
    files:
      - logic/hdmi_pkg.sv
      - logic/byte_packer.sv
      - logic/vram_plane.sv
      - logic/scan_reader.sv
      - logic/hdmi_frame_top.sv

  # simulation only
  - target: test
    include_dirs:
      - logic
      - tests
    files:
      - tests/hdmi_frame_tb.sv

// File: tests/hdmi_frame_checks.svh
`ifndef HDMI_FRAME_CHECKS_SVH
`define HDMI_FRAME_CHECKS_SVH

// ==============================
// result counters
// ==============================
int check_cnt = 0; // compares done
int error_cnt = 0; // compares failed

// one output pixel against the frame model
task automatic check_pixel(input string name, input hdmi_pkg::rgb_t got,
                           input hdmi_pkg::rgb_t exp);
   check_cnt++;
   if (got !== exp) begin
      error_cnt++;
      $display("Error at %0d ns: %s got %h expected %h", $time, name, got, exp);
   end
endtask

// pulse width, period or count, in cycles
task automatic check_cycles(input string name, input int got, input int exp);
   check_cnt++;
   if (got != exp) begin
      error_cnt++;
      $display("Error at %0d ns: %s got %0d expected %0d", $time, name, got, exp);
   end
endtask

// static level of a single output
task automatic check_level(input string name, input logic got, input logic exp);
   check_cnt++;
   if (got !== exp) begin
      error_cnt++;
      $display("Error at %0d ns: %s got %b expected %b", $time, name, got, exp);
   end
endtask

`endif

// File: tests/hdmi_frame_tb.sv
`include "hdmi_defs.svh"

module hdmi_frame_tb;
   timeunit 1ns;
   timeprecision 1ps;
   import hdmi_pkg::*;

   localparam int H_TOTAL    = `H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK; // 48
   localparam int V_TOTAL    = `V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK; // 22
   localparam int FRAME_CYC  = H_TOTAL * V_TOTAL;
   localparam int WAIT_LIMIT = 4 * FRAME_CYC; // cycles before any wait gives up
   localparam logic SYNC_ON  = 1'(`SYNC_ACTIVE);

   logic  clk;
   logic  rst_n;
   logic  data_valid;
   byte_t data_in;
   rgb_t  rgb;
   logic  hsync;
   logic  vsync;
   logic  de;

   rgb_t   shadow [`VRAM_DEPTH]; // frame model, what the planes should hold
   plane_t ref_phase = PLANE_R;
   int     ref_addr  = 0;
   int     frame_req   = 0; // frame compares asked for
   int     frame_start = 0; // frame compares begun
   int     frame_done  = 0; // frame compares finished
   bit     pix_en      = 1'b1;
   int     test_cnt    = 0;
   int     test_err0   = 0;

   `include "hdmi_frame_checks.svh"

   hdmi_frame_top dut0 (
      .clk        (clk),
      .rst_n      (rst_n),
      .data_in    (data_in),
      .data_valid (data_valid),
      .rgb        (rgb),
      .hsync      (hsync),
      .vsync      (vsync),
      .de         (de)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk; // 40 ns period
   end

   // ==============================
   // reference model
   // ==============================
   function automatic void model_byte(input byte_t b);
      case (ref_phase)
         PLANE_R: shadow[ref_addr].red   = b;
         PLANE_G: shadow[ref_addr].green = b;
         default: shadow[ref_addr].blue  = b;
      endcase
      if (ref_phase == PLANE_B) ref_addr = (ref_addr + 1) % `VRAM_DEPTH; // wrap at full
      ref_phase = (ref_phase == PLANE_B) ? PLANE_R : plane_t'(ref_phase + 1);
   endfunction

   function automatic rgb_t expected_pixel(input int x, input int y);
      return shadow[y * `H_ACTIVE + x]; // raster address
   endfunction

   function automatic bit is_sync(input bit use_v);
      return use_v ? (vsync === SYNC_ON) : (hsync === SYNC_ON);
   endfunction

   task automatic abort_run(input string what);
      $display("timeout while waiting for %s", what);
      $display("=== FAIL ===");
      $finish;
   endtask

   // ==============================
   // comparing process
   // ==============================
   int   x_pos = 0;
   int   y_pos = 0;
   int   frame_lines = 0;
   bit   checking = 1'b0;
   logic de_d = 1'b0;
   logic vs_d = 1'b0;

   always @(negedge clk) begin
      if (checking && de === 1'b0)
         check_pixel("rgb in blanking", rgb, '0); // black outside the picture
      if (vsync === SYNC_ON && vs_d !== SYNC_ON) begin // frame boundary
         if (checking) begin
            check_cycles("lines with de", frame_lines, `V_ACTIVE);
            checking = 1'b0;
            frame_done++;
         end
         if (frame_start != frame_req) begin
            frame_start = frame_req;
            checking    = 1'b1;
         end
         x_pos = 0;
         y_pos = 0;
         frame_lines = 0;
      end else if (de === 1'b1) begin
         if (checking && pix_en && x_pos < `H_ACTIVE && y_pos < `V_ACTIVE)
            check_pixel($sformatf("rgb x %0d y %0d", x_pos, y_pos), rgb,
                        expected_pixel(x_pos, y_pos));
         x_pos++;
      end else if (de_d === 1'b1) begin // line just ended
         if (checking) begin
            check_cycles("de per line", x_pos, `H_ACTIVE);
            frame_lines++;
         end
         x_pos = 0;
         y_pos++;
      end
      de_d = de;
      vs_d = vsync;
   end

   // ==============================
   // stimulus and waits
   // ==============================
   task automatic send_byte(input byte_t b); // entered at posedge + 5
      data_in    = b;
      data_valid = 1'b1;
      model_byte(b);
      @(posedge clk); // accepted here
      #5 data_valid = 1'b0;
   endtask

   task automatic send_bytes(input int count, input bit gaps);
      int idle;
      for (int i = 0; i < count; i++) begin
         if (gaps && $urandom_range(3, 0) == 0) begin
            idle = $urandom_range(3, 1); // valid low, phase held
            repeat (idle) @(posedge clk);
            #5;
         end
         send_byte(byte_t'($urandom));
      end
   endtask

   task automatic apply_reset();
      rst_n      = 1'b0;
      data_valid = 1'b0;
      repeat (2) begin
         @(posedge clk);
         #5 check_level("de", de, 1'b0);
         check_level("hsync", hsync, ~SYNC_ON);
         check_level("vsync", vsync, ~SYNC_ON);
      end
      rst_n     = 1'b1;
      ref_phase = PLANE_R; // packer restarts at red, address 0
      ref_addr  = 0;
      // counters restart at the origin, first pixel one edge after release
      @(posedge clk);
      #5 check_level("de", de, 1'b1);
      check_level("hsync", hsync, ~SYNC_ON);
      check_level("vsync", vsync, ~SYNC_ON);
   endtask

   task automatic verify_next_frame();
      int n;
      frame_req++;
      n = 0;
      while (frame_done != frame_req && n < WAIT_LIMIT) begin
         @(posedge clk);
         n++;
      end
      if (frame_done != frame_req) abort_run("a full frame to compare");
      #5;
   endtask

   task automatic wait_sync(input bit use_v, input bit level, output int cycles);
      cycles = 0;
      do begin
         @(negedge clk);
         cycles++;
      end while (is_sync(use_v) != level && cycles < WAIT_LIMIT);
      if (is_sync(use_v) != level) abort_run(use_v ? "a vsync edge" : "an hsync edge");
   endtask

   task automatic measure_sync(input bit use_v, input int width_exp, input int period_exp);
      int c;
      int width;
      int rest;
      wait_sync(use_v, 1'b0, c);
      wait_sync(use_v, 1'b1, c);     // first cycle of a pulse
      wait_sync(use_v, 1'b0, width);
      wait_sync(use_v, 1'b1, rest);  // up to the next pulse
      check_cycles(use_v ? "vsync width" : "hsync width", width, width_exp);
      check_cycles(use_v ? "vsync period" : "hsync period", width + rest, period_exp);
      @(posedge clk);
      #5;
   endtask

   task automatic finish_test(input string name);
      test_cnt++;
      $display("test %0d %s: %s", test_cnt, name,
               (error_cnt == test_err0) ? "ok" : "FAILED");
      test_err0 = error_cnt;
   endtask

   // ==============================
   // test sequence
   // ==============================
   initial begin
      rst_n      = 1'b0;
      data_valid = 1'b0;
      data_in    = '0;
      void'($urandom(32'h03da1322));
      apply_reset();
      finish_test("reset state");
      measure_sync(1'b0, `H_SYNC, H_TOTAL);
      measure_sync(1'b1, `V_SYNC * H_TOTAL, FRAME_CYC);
      pix_en = 1'b0; // planes still uninitialized
      verify_next_frame();
      pix_en = 1'b1;
      finish_test("sync timing");
      send_bytes(3 * `VRAM_DEPTH, 1'b0);
      verify_next_frame();
      finish_test("frame load");
      send_bytes(3 * `VRAM_DEPTH, 1'b1);
      verify_next_frame();
      finish_test("gapped input");
      send_bytes(3 * 20, 1'b0); // pixels 0 to 19 only
      verify_next_frame();
      finish_test("wraparound");
      send_bytes(2, 1'b0); // red and green, no blue
      apply_reset();
      send_bytes(3 * `VRAM_DEPTH, 1'b0);
      verify_next_frame();
      finish_test("reset mid-pixel");
      $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, error_cnt);
      if (error_cnt == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

// File: logic/hdmi_frame_top.sv
module hdmi_frame_top (
   input  logic            clk,        // single clock, pixel and byte
   input  logic            rst_n,
   input  hdmi_pkg::byte_t data_in,    // byte stream in
   input  logic            data_valid,
   output hdmi_pkg::rgb_t  rgb,        // toward the TMDS encoder
   output logic            hsync,
   output logic            vsync,
   output logic            de
);
   import hdmi_pkg::*;

   // ==============================
   // packer to planes
   // ==============================
   logic [2:0] wr_en;   // one bit per plane
   byte_t      wr_data;
   vram_addr_t wr_addr;

   // ==============================
   // planes to reader
   // ==============================
   vram_addr_t rd_addr;     // shared by all planes
   byte_t      plane_rd [3]; // indexed by plane_t
   rgb_t       rd_rgb;

   byte_packer byte_packer_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .data_in    (data_in),
      .data_valid (data_valid),
      .wr_en      (wr_en),
      .wr_data    (wr_data),
      .wr_addr    (wr_addr)
   );

   // one memory per colour, same address on both sides
   for (genvar p = PLANE_R; p <= PLANE_B; p++) begin : g_plane
      vram_plane vram_plane_i (
         .clk     (clk),
         .wr_en   (wr_en[p]), // only this plane's phase
         .wr_addr (wr_addr),
         .wr_data (wr_data),
         .rd_addr (rd_addr),
         .rd_data (plane_rd[p])
      );
   end

   // planes back into one pixel, red on top
   assign rd_rgb.red   = plane_rd[PLANE_R];
   assign rd_rgb.green = plane_rd[PLANE_G];
   assign rd_rgb.blue  = plane_rd[PLANE_B];

   scan_reader scan_reader_i (
      .clk     (clk),
      .rst_n   (rst_n),
      .rd_addr (rd_addr),
      .rd_data (rd_rgb),
      .rgb     (rgb),
      .hsync   (hsync),
      .vsync   (vsync),
      .de      (de)
   );

endmodule

// File: logic/scan_reader.sv
`include "hdmi_defs.svh"

module scan_reader (
   input  logic                 clk,
   input  logic                 rst_n,
   output hdmi_pkg::vram_addr_t rd_addr, // to all three planes
   input  hdmi_pkg::rgb_t       rd_data, // planes, one cycle after rd_addr
   output hdmi_pkg::rgb_t       rgb,     // zero outside the active area
   output logic                 hsync,
   output logic                 vsync,
   output logic                 de
);
   import hdmi_pkg::*;

   // ==============================
   // derived timing
   // ==============================
   localparam int H_TOTAL = `H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK; // 48
   localparam int V_TOTAL = `V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK; // 22
   localparam int HW      = $clog2(H_TOTAL);
   localparam int VW      = $clog2(V_TOTAL);

   // sync windows sit after the front porch
   localparam int HS_START = `H_ACTIVE + `H_FRONT;
   localparam int HS_END   = HS_START + `H_SYNC;
   localparam int VS_START = `V_ACTIVE + `V_FRONT;
   localparam int VS_END   = VS_START + `V_SYNC;

   localparam logic SYNC_ON  = 1'(`SYNC_ACTIVE);
   localparam logic SYNC_OFF = ~SYNC_ON;

   logic [HW-1:0] h_cnt;    // pixel within line
   logic [VW-1:0] v_cnt;    // line within frame
   logic          h_last;
   logic          v_last;
   logic          active;   // current counters inside the picture
   logic          hs_win;
   logic          vs_win;
   vram_addr_t    pix_addr; // address of the pixel at the counters

   // ==============================
   // timing counters
   // ==============================
   assign h_last = (h_cnt == HW'(H_TOTAL - 1));
   assign v_last = (v_cnt == VW'(V_TOTAL - 1));

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         h_cnt <= '0; // origin
         v_cnt <= '0;
      end else begin
         if (h_last) begin
            h_cnt <= '0;
            // line step only at end of line
            if (v_last) begin
               v_cnt <= '0;
            end else begin
               v_cnt <= v_cnt + VW'(1);
            end
         end else begin
            h_cnt <= h_cnt + HW'(1);
         end
      end
   end

   // decode of the current counter state
   assign active = (h_cnt < HW'(`H_ACTIVE)) && (v_cnt < VW'(`V_ACTIVE));
   assign hs_win = (h_cnt >= HW'(HS_START)) && (h_cnt < HW'(HS_END));
   assign vs_win = (v_cnt >= VW'(VS_START)) && (v_cnt < VW'(VS_END));

   // ==============================
   // read addressing
   // ==============================
   // runs y * H_ACTIVE + x without a multiplier
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pix_addr <= '0;
      end else if (h_last && v_last) begin
         pix_addr <= '0; // next cycle is the origin
      end else if (active) begin
         pix_addr <= pix_addr + vram_addr_t'(1);
      end
      // blanking holds the address of the next visible pixel
   end

   assign rd_addr = pix_addr; // planes register it, data lands at t+1

   // ==============================
   // output stage
   // ==============================
   // one register stage, lines up with the plane read latency
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         de    <= 1'b0;
         hsync <= SYNC_OFF; // inactive level
         vsync <= SYNC_OFF;
      end else begin
         de    <= active;
         hsync <= hs_win ? SYNC_ON : SYNC_OFF;
         vsync <= vs_win ? SYNC_ON : SYNC_OFF;
      end
   end

   // blank outside the picture, stale plane data never shows
   assign rgb = de ? rd_data : '0;

   // active area and hsync pulse must not overlap on the output
   a_de_not_in_hsync : assert property (
      @(posedge clk) disable iff (!rst_n)
      de |-> (hsync != SYNC_ON)
   ) else $error("scan_reader: de during hsync");

endmodule

// File: logic/vram_plane.sv
`include "hdmi_defs.svh"

module vram_plane (
   input  logic                 clk,
   input  logic                 wr_en,   // from packer, one plane at a time
   input  hdmi_pkg::vram_addr_t wr_addr,
   input  hdmi_pkg::byte_t      wr_data,
   input  hdmi_pkg::vram_addr_t rd_addr, // from scan reader
   output hdmi_pkg::byte_t      rd_data  // one cycle after rd_addr
);
   import hdmi_pkg::*;

   // ==============================
   // storage
   // ==============================
   // one byte per pixel of this colour
   byte_t mem [`VRAM_DEPTH];

   // write port
   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_addr] <= wr_data;
      end
   end

   // ==============================
   // read port
   // ==============================
   // registered read, maps onto a block ram output register
   // same-address collision returns the byte before the write
   always_ff @(posedge clk) begin
      rd_data <= mem[rd_addr];
   end

   // packer wrap must keep writes inside the plane
   a_wr_addr_range : assert property (
      @(posedge clk)
      wr_en |-> (int'(wr_addr) < `VRAM_DEPTH)
   ) else $error("vram_plane: write address %0d out of range", wr_addr);

endmodule

// File: logic/byte_packer.sv
`include "hdmi_defs.svh"

module byte_packer (
   input  logic                 clk,
   input  logic                 rst_n,
   input  hdmi_pkg::byte_t      data_in,    // byte stream, r g b r g b ...
   input  logic                 data_valid, // no back-pressure
   output logic [2:0]           wr_en,      // one-hot, one bit per plane
   output hdmi_pkg::byte_t      wr_data,    // shared by all planes
   output hdmi_pkg::vram_addr_t wr_addr     // shared by all planes
);
   import hdmi_pkg::*;

   // last pixel of the buffer, wrap point
   localparam vram_addr_t ADDR_LAST = vram_addr_t'(`VRAM_DEPTH - 1);

   plane_t     phase;     // plane of the next accepted byte
   plane_t     phase_nxt;
   vram_addr_t pix_addr;  // pixel being assembled

   // ==============================
   // byte phase sequence
   // ==============================
   always_comb begin
      case (phase)
         PLANE_R: phase_nxt = PLANE_G;
         PLANE_G: phase_nxt = PLANE_B;
         PLANE_B: phase_nxt = PLANE_R; // pixel done
         default: phase_nxt = PLANE_R; // unused encoding, recover
      endcase
   end

   // ==============================
   // control state
   // ==============================
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         phase    <= PLANE_R;
         pix_addr <= '0;
         wr_en    <= '0;
      end else begin
         wr_en <= '0; // single cycle strobe
         if (data_valid) begin
            // bit index equals the plane encoding
            wr_en <= 3'(1) << phase;
            phase <= phase_nxt;
            // address moves only once the blue byte is in
            if (phase == PLANE_B) begin
               if (pix_addr == ADDR_LAST) begin
                  pix_addr <= '0; // buffer full, start over
               end else begin
                  pix_addr <= pix_addr + vram_addr_t'(1);
               end
            end
         end
         // gaps in data_valid hold phase and address
      end
   end

   // ==============================
   // write payload
   // ==============================
   // captured with the accepted byte, used one cycle later
   always_ff @(posedge clk) begin
      if (data_valid) begin
         wr_data <= data_in;
         wr_addr <= pix_addr; // address before any increment
      end
   end

   // planes share data and address, so at most one may write
   a_wr_en_onehot0 : assert property (
      @(posedge clk) disable iff (!rst_n)
      $onehot0(wr_en)
   ) else $error("byte_packer: wr_en not one-hot %b", wr_en);

endmodule

// File: logic/hdmi_pkg.sv
`include "hdmi_defs.svh"

package hdmi_pkg;

   // ==============================
   // payload types
   // ==============================

   // one colour sample, as it arrives on the byte stream
   typedef logic [7:0] byte_t;

   // pixel address, y * H_ACTIVE + x
   typedef logic [`VRAM_AW-1:0] vram_addr_t;

   // full pixel, red on top
   typedef struct packed {
      byte_t red;   // bits 23:16
      byte_t green; // bits 15:8
      byte_t blue;  // bits 7:0
   } rgb_t;

   // ==============================
   // plane select
   // ==============================

   // byte phase of the packer and index of the plane memories
   // value doubles as the bit position in the one-hot write enable
   typedef enum logic [1:0] {
      PLANE_R = 2'd0, // first byte of a pixel
      PLANE_G = 2'd1,
      PLANE_B = 2'd2  // last byte, address steps after it
   } plane_t;

endpackage

// File: logic/hdmi_defs.svh
`ifndef HDMI_DEFS_SVH
`define HDMI_DEFS_SVH

// ==============================
// horizontal timing in pixels
// ==============================
// line order is active, front porch, sync, back porch
`define H_ACTIVE 32 // visible pixels per line
`define H_FRONT 4   // front porch
`define H_SYNC 6    // hsync pulse width
`define H_BACK 6    // back porch

// ==============================
// vertical timing in lines
// ==============================
`define V_ACTIVE 16 // visible lines per frame
`define V_FRONT 2
`define V_SYNC 2    // vsync pulse width
`define V_BACK 2

// sync polarity, level while asserted
`define SYNC_ACTIVE 1

// ==============================
// frame buffer
// ==============================
// one plane holds exactly one visible frame
`define VRAM_DEPTH 512 // H_ACTIVE * V_ACTIVE
`define VRAM_AW 9      // pixel address width

`endif
